/* build.f */
logic/cache_pkg.sv
logic/tag_array.sv
logic/data_array.sv
logic/cache_ctrl.sv
logic/cache_top.sv
testbench/mem_model.sv
testbench/tb_cache.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the data cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_cache -f build.f -o tb_cache
if [ $? -ne 0 ]; then
  echo "verilator compile failed"
  exit 1
fi

out=$(./obj_dir/tb_cache)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "Simulation PASSED"; then
  exit 0
fi
exit 1

/* testbench/tb_cache.sv */
// Data cache testbench

`timescale 1ns/1ps

module tb_cache import cache_pkg::*; ();

  localparam logic [31:0] RAND_SEED = 32'hf065;
  localparam logic [31:0] PAT_MULT  = 32'h9e3779b1;
  localparam int          TIMEOUT   = 200;       // cycles per wait

  typedef struct {
    string             name;
    logic              op;                      // 1 for store
    logic [ADDR_W-1:0] addr;
    logic [STRB_W-1:0] strb;
    logic [DATA_W-1:0] data;
    logic              one_cycle;               // expect a hit
  } entry_t;

  logic              i_clk, i_rst, i_valid, i_op;
  logic [ADDR_W-1:0] i_addr;
  logic [STRB_W-1:0] i_wstrb;
  logic [DATA_W-1:0] i_wdata, o_rdata, i_ret_data;
  logic              o_addr_ok, o_data_ok, o_rd_req, i_rd_rdy, o_wr_req, i_wr_rdy;
  logic              i_ret_valid, i_ret_last;
  logic [ADDR_W-1:0] o_rd_addr, o_wr_addr;
  logic [LINE_W-1:0] o_wr_data;
  entry_t            tests[$];
  logic [7:0]        shadow [logic [31:0]];     // bytes stored so far
  int                errors, mem_errors;
  bit                timed_out;

  cache_top i_cache_top (.*);

  mem_model i_mem_model (
    .i_clk (i_clk), .i_rst (i_rst), .i_seed (RAND_SEED), .i_pat_mult (PAT_MULT),
    .i_rd_req (o_rd_req), .i_rd_addr (o_rd_addr), .o_rd_rdy (i_rd_rdy),
    .o_ret_valid (i_ret_valid), .o_ret_last (i_ret_last), .o_ret_data (i_ret_data),
    .i_wr_req (o_wr_req), .i_wr_addr (o_wr_addr), .i_wr_data (o_wr_data),
    .o_wr_rdy (i_wr_rdy), .o_err_cnt (mem_errors)
  );

  initial begin
    i_clk = 1'b0;
    forever #2 i_clk = ~i_clk;
  end

  function automatic logic [DATA_W-1:0] shadow_word(input logic [ADDR_W-1:0] addr);
    logic [31:0]       p;
    logic [31:0]       base;
    logic [DATA_W-1:0] w;
    p    = (addr >> 3) * PAT_MULT;
    base = {addr[ADDR_W-1:3], 3'b000};
    w    = {p, p};                               // memory pattern
    for (int b = 0; b < STRB_W; b++)
      if (shadow.exists(base + b)) w[b*8 +: 8] = shadow[base + b];
    return w;
  endfunction

  task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
    assert (act === exp) else begin
      $display("** Error: %s expected %h actual %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic add_entry(input string name, input logic op, input logic [31:0] addr,
                           input logic [7:0] strb, input logic [63:0] data, input logic one);
    tests.push_back('{name, op, addr, strb, data, one});
  endtask

  // ------------------------------------------------------------
  // one request from issue to o_data_ok
  // ------------------------------------------------------------
  task automatic run_entry(input entry_t e);
    int                cnt;
    bit                seen;
    logic [DATA_W-1:0] exp, rdata;
    exp     = shadow_word(e.addr);
    i_valid <= 1'b1;
    i_op    <= e.op;
    i_addr  <= e.addr;
    i_wstrb <= e.strb;
    i_wdata <= e.data;
    seen = 1'b0;
    cnt  = 0;
    while (!seen && cnt < TIMEOUT) begin
      @(posedge i_clk);
      seen = o_addr_ok;                          // valid was high this cycle
      cnt++;
    end
    i_valid <= 1'b0;
    assert (seen) else begin
      $display("timeout: %s was not accepted within %0d cycles", e.name, TIMEOUT);
      errors++;
      timed_out = 1'b1;
    end
    if (seen) begin
      seen = 1'b0;
      cnt  = 0;
      while (!seen && cnt < TIMEOUT) begin
        @(posedge i_clk);
        cnt++;
        seen  = o_data_ok;
        rdata = o_rdata;
      end
      assert (seen) else begin
        $display("timeout: %s got no o_data_ok within %0d cycles", e.name, TIMEOUT);
        errors++;
        timed_out = 1'b1;
      end
      if (seen && e.one_cycle) check_value({e.name, " latency"}, 64'd1, 64'(cnt));
      if (seen && !e.op) check_value(e.name, exp, rdata);
      if (seen && e.op) begin
        for (int b = 0; b < STRB_W; b++)
          if (e.strb[b]) shadow[{e.addr[ADDR_W-1:3], 3'b000} + b] = e.data[b*8 +: 8];
      end
    end
  endtask

  initial begin
    i_rst     = 1'b1;
    i_valid   = 1'b0;
    i_op      = 1'b0;
    i_addr    = '0;
    i_wstrb   = '0;
    i_wdata   = '0;
    errors    = 0;
    timed_out = 1'b0;
    // index 5 for tags 1, 2 and 3, index 0x38 for the store miss
    add_entry("load_miss",       1'b0, 32'h0000_08a8, 8'h00, 64'h0, 1'b0);
    add_entry("load_hit",        1'b0, 32'h0000_08b0, 8'h00, 64'h0, 1'b1);
    add_entry("store_hit_part",  1'b1, 32'h0000_08a8, 8'h35, 64'h1122_3344_5566_7788, 1'b1);
    add_entry("load_merged",     1'b0, 32'h0000_08a8, 8'h00, 64'h0, 1'b1);
    add_entry("fill_way_one",    1'b0, 32'h0000_10a0, 8'h00, 64'h0, 1'b0);
    add_entry("evict_dirty",     1'b0, 32'h0000_18b8, 8'h00, 64'h0, 1'b0);
    add_entry("reload_dirty",    1'b0, 32'h0000_08a8, 8'h00, 64'h0, 1'b0);
    add_entry("store_miss",      1'b1, 32'h0000_3f18, 8'hf0, 64'hdead_beef_cafe_f00d, 1'b0);
    add_entry("load_store_miss", 1'b0, 32'h0000_3f18, 8'h00, 64'h0, 1'b1);
    add_entry("store_hit_full",  1'b1, 32'h0000_18b8, 8'hff, 64'h0123_4567_89ab_cdef, 1'b1);
    add_entry("evict_clean",     1'b0, 32'h0000_10a0, 8'h00, 64'h0, 1'b0);
    add_entry("evict_full",      1'b0, 32'h0000_08b8, 8'h00, 64'h0, 1'b0);
    add_entry("reload_full",     1'b0, 32'h0000_18b8, 8'h00, 64'h0, 1'b0);
    repeat (3) @(posedge i_clk);
    i_rst <= 1'b0;
    @(posedge i_clk);
    check_value("reset o_addr_ok", 64'd1, 64'(o_addr_ok));
    check_value("reset o_data_ok", 64'd0, 64'(o_data_ok));
    check_value("reset o_rd_req", 64'd0, 64'(o_rd_req));
    check_value("reset o_wr_req", 64'd0, 64'(o_wr_req));
    for (int i = 0; i < tests.size() && !timed_out; i++) run_entry(tests[i]);
    repeat (2) @(posedge i_clk);
    $display("errors: %0d in testbench, %0d in memory model", errors, mem_errors);
    if (errors == 0 && mem_errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

/* testbench/mem_model.sv */
// Memory bus responder

`timescale 1ns/1ps

module mem_model import cache_pkg::*; (
  input  logic              i_clk,
  input  logic              i_rst,
  input  logic [31:0]       i_seed,
  input  logic [31:0]       i_pat_mult,
  input  logic              i_rd_req,
  input  logic [ADDR_W-1:0] i_rd_addr,
  output logic              o_rd_rdy,
  output logic              o_ret_valid,
  output logic              o_ret_last,
  output logic [DATA_W-1:0] o_ret_data,
  input  logic              i_wr_req,
  input  logic [ADDR_W-1:0] i_wr_addr,
  input  logic [LINE_W-1:0] i_wr_data,
  output logic              o_wr_rdy,
  output int                o_err_cnt
);

  logic [DATA_W-1:0] store [logic [31:0]];  // only words written back
  integer            seed;
  logic [31:0]       line_wa;

  // untouched words follow the fill pattern
  function automatic logic [DATA_W-1:0] read_word(input logic [31:0] wa);
    logic [31:0] p;
    p = wa * i_pat_mult;
    if (store.exists(wa)) return store[wa];
    return {p, p};
  endfunction

  function automatic int draw_gap();
    return $unsigned($random(seed)) % 4;  // 0 to 3 cycles
  endfunction

  // ------------------------------------------------------------
  // one transaction at a time, write-back before refill
  // ------------------------------------------------------------
  initial begin
    int gap;
    o_rd_rdy    = 1'b0;
    o_ret_valid = 1'b0;
    o_ret_last  = 1'b0;
    o_ret_data  = '0;
    o_wr_rdy    = 1'b0;
    o_err_cnt   = 0;
    @(posedge i_clk);
    seed = i_seed;
    forever begin
      @(posedge i_clk);
      if (!i_rst && i_wr_req) begin
        gap = draw_gap();
        repeat (gap) @(posedge i_clk);
        o_wr_rdy <= 1'b1;
        @(posedge i_clk);                       // line taken here
        o_wr_rdy <= 1'b0;
        assert (i_wr_req) else begin
          $display("memory model: write-back taken while o_wr_req was low");
          o_err_cnt++;
        end
        assert (i_wr_addr[OFFSET_W-1:0] == '0) else begin
          $display("memory model: write-back address %h is not line aligned", i_wr_addr);
          o_err_cnt++;
        end
        for (int w = 0; w < WORDS_PER_LINE; w++)
          store[(i_wr_addr >> 3) + w] = i_wr_data[w*DATA_W +: DATA_W];
      end else if (!i_rst && i_rd_req) begin
        gap = draw_gap();
        repeat (gap) @(posedge i_clk);
        o_rd_rdy <= 1'b1;
        @(posedge i_clk);
        o_rd_rdy <= 1'b0;
        line_wa = i_rd_addr >> 3;
        for (int b = 0; b < WORDS_PER_LINE; b++) begin
          gap = draw_gap();
          o_ret_valid <= 1'b0;                  // gap between beats
          repeat (gap) @(posedge i_clk);
          o_ret_valid <= 1'b1;
          o_ret_data  <= read_word(line_wa + b);
          o_ret_last  <= (b == WORDS_PER_LINE - 1);
          @(posedge i_clk);
        end
        o_ret_valid <= 1'b0;
        o_ret_last  <= 1'b0;
      end
    end
  end

endmodule

/* logic/cache_top.sv */
// Data cache top level

`timescale 1ns/1ps

module cache_top import cache_pkg::*; (
  input  logic                i_clk,
  input  logic                i_rst,
  // cpu side
  input  logic                i_valid,
  input  logic                i_op,         // 1 for store
  input  cache_addr_t         i_addr,
  input  logic [STRB_W-1:0]   i_wstrb,
  input  logic [DATA_W-1:0]   i_wdata,
  output logic                o_addr_ok,
  output logic                o_data_ok,
  output logic [DATA_W-1:0]   o_rdata,
  // memory side
  output logic                o_rd_req,
  output logic [ADDR_W-1:0]   o_rd_addr,
  input  logic                i_rd_rdy,
  input  logic                i_ret_valid,
  input  logic                i_ret_last,
  input  logic [DATA_W-1:0]   i_ret_data,
  output logic                o_wr_req,
  output logic [ADDR_W-1:0]   o_wr_addr,
  output logic [LINE_W-1:0]   o_wr_data,
  input  logic                i_wr_rdy
);

  logic [INDEX_W-1:0]    index;
  logic [TAG_W-1:0]      tag;
  logic                  set_dirty;
  logic                  fill_tag;
  logic                  fill_way;
  logic                  victim_way;
  logic                  hit;
  logic                  hit_way;
  logic                  victim_dirty;
  logic [TAG_W-1:0]      victim_tag;
  logic                  word_we;
  logic                  word_way;
  logic [WORD_SEL_W-1:0] word_sel;
  logic [STRB_W-1:0]     word_strb;
  logic [DATA_W-1:0]     word_data;

  cache_ctrl i_cache_ctrl (
    .i_clk          (i_clk),
    .i_rst          (i_rst),
    .i_valid        (i_valid),
    .i_op           (i_op),
    .i_addr         (i_addr),
    .i_wstrb        (i_wstrb),
    .i_wdata        (i_wdata),
    .o_addr_ok      (o_addr_ok),
    .o_data_ok      (o_data_ok),
    .o_rd_req       (o_rd_req),
    .o_rd_addr      (o_rd_addr),
    .i_rd_rdy       (i_rd_rdy),
    .i_ret_valid    (i_ret_valid),
    .i_ret_last     (i_ret_last),
    .i_ret_data     (i_ret_data),
    .o_wr_req       (o_wr_req),
    .o_wr_addr      (o_wr_addr),
    .i_wr_rdy       (i_wr_rdy),
    .o_index        (index),
    .o_tag          (tag),
    .o_set_dirty    (set_dirty),
    .o_fill_tag     (fill_tag),
    .o_fill_way     (fill_way),
    .o_victim_way   (victim_way),
    .i_hit          (hit),
    .i_hit_way      (hit_way),
    .i_victim_dirty (victim_dirty),
    .i_victim_tag   (victim_tag),
    .o_word_we      (word_we),
    .o_word_way     (word_way),
    .o_word_sel     (word_sel),
    .o_word_strb    (word_strb),
    .o_word_data    (word_data)
  );

  tag_array i_tag_array (
    .i_clk          (i_clk),
    .i_rst          (i_rst),
    .i_index        (index),
    .i_tag          (tag),
    .i_set_dirty    (set_dirty),
    .i_fill_tag     (fill_tag),
    .i_fill_way     (fill_way),
    .i_victim_way   (victim_way),
    .o_hit          (hit),
    .o_hit_way      (hit_way),
    .o_victim_dirty (victim_dirty),
    .o_victim_tag   (victim_tag)
  );

  // load word goes straight out, valid with o_data_ok
  data_array i_data_array (
    .i_clk          (i_clk),
    .i_index        (index),
    .i_hit_way      (hit_way),
    .i_victim_way   (victim_way),
    .i_word_sel     (word_sel),
    .i_word_we      (word_we),
    .i_word_way     (word_way),
    .i_word_strb    (word_strb),
    .i_word_data    (word_data),
    .o_rdata_word   (o_rdata),
    .o_victim_line  (o_wr_data)
  );

endmodule

/* logic/cache_ctrl.sv */
// Data cache controller

`timescale 1ns/1ps

module cache_ctrl import cache_pkg::*; (
  input  logic                  i_clk,
  input  logic                  i_rst,
  // cpu side
  input  logic                  i_valid,
  input  logic                  i_op,
  input  cache_addr_t           i_addr,
  input  logic [STRB_W-1:0]     i_wstrb,
  input  logic [DATA_W-1:0]     i_wdata,
  output logic                  o_addr_ok,
  output logic                  o_data_ok,
  // memory side
  output logic                  o_rd_req,
  output logic [ADDR_W-1:0]     o_rd_addr,
  input  logic                  i_rd_rdy,
  input  logic                  i_ret_valid,
  input  logic                  i_ret_last,
  input  logic [DATA_W-1:0]     i_ret_data,
  output logic                  o_wr_req,
  output logic [ADDR_W-1:0]     o_wr_addr,
  input  logic                  i_wr_rdy,
  // tag array
  output logic [INDEX_W-1:0]    o_index,
  output logic [TAG_W-1:0]      o_tag,
  output logic                  o_set_dirty,
  output logic                  o_fill_tag,
  output logic                  o_fill_way,
  output logic                  o_victim_way,
  input  logic                  i_hit,
  input  logic                  i_hit_way,
  input  logic                  i_victim_dirty,
  input  logic [TAG_W-1:0]      i_victim_tag,
  // data array
  output logic                  o_word_we,
  output logic                  o_word_way,
  output logic [WORD_SEL_W-1:0] o_word_sel,
  output logic [STRB_W-1:0]     o_word_strb,
  output logic [DATA_W-1:0]     o_word_data
);

  logic [2:0]            state_q, state_d;
  cache_addr_t           req_addr;
  logic                  req_op;
  logic [STRB_W-1:0]     req_wstrb;
  logic [DATA_W-1:0]     req_wdata;
  logic [WORD_SEL_W-1:0] beat_cnt;
  logic                  victim_ptr;
  cache_addr_t           rd_line, wr_line;
  logic                  in_lookup, in_refill, store_hit, ret_beat;

  assign in_lookup = (state_q == ST_LOOKUP);
  assign in_refill = (state_q == ST_REFILL);
  assign store_hit = in_lookup && i_hit && req_op;
  assign ret_beat  = in_refill && i_ret_valid;

  // ------------------------------------------------------------
  // request register
  // ------------------------------------------------------------
  always_ff @(posedge i_clk) begin
    if (i_valid && o_addr_ok) begin
      req_addr  <= i_addr;
      req_op    <= i_op;
      req_wstrb <= i_wstrb;
      req_wdata <= i_wdata;
    end
  end

  // ------------------------------------------------------------
  // state machine
  // ------------------------------------------------------------
  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE:       if (i_valid) state_d = ST_LOOKUP;
      ST_LOOKUP: begin
        if (i_hit)               state_d = ST_IDLE;
        else if (i_victim_dirty) state_d = ST_WRITEBACK;
        else                     state_d = ST_REFILL_REQ;
      end
      ST_WRITEBACK:  if (i_wr_rdy) state_d = ST_REFILL_REQ;
      ST_REFILL_REQ: if (i_rd_rdy) state_d = ST_REFILL;
      ST_REFILL:     if (i_ret_valid && i_ret_last) state_d = ST_LOOKUP;  // repeat lookup now hits
      default:       state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state_q    <= ST_IDLE;
      beat_cnt   <= '0;
      victim_ptr <= 1'b0;
    end else begin
      state_q <= state_d;
      if (state_q == ST_REFILL_REQ && i_rd_rdy) beat_cnt <= '0;
      else if (ret_beat) beat_cnt <= beat_cnt + 1'b1;
      if (o_fill_tag) victim_ptr <= ~victim_ptr;  // toggles per refill
    end
  end

  // cpu handshake
  assign o_addr_ok = (state_q == ST_IDLE);
  assign o_data_ok = in_lookup && i_hit;

  // ------------------------------------------------------------
  // bus addresses, line aligned
  // ------------------------------------------------------------
  always_comb begin
    rd_line.f.tag    = req_addr.f.tag;
    rd_line.f.index  = req_addr.f.index;
    rd_line.f.offset = '0;
    wr_line.f.tag    = i_victim_tag;      // victim goes back to its own address
    wr_line.f.index  = req_addr.f.index;
    wr_line.f.offset = '0;
  end

  assign o_rd_req  = (state_q == ST_REFILL_REQ);
  assign o_rd_addr = rd_line.raw;
  assign o_wr_req  = (state_q == ST_WRITEBACK);
  assign o_wr_addr = wr_line.raw;

  // array control
  assign o_index      = req_addr.f.index;
  assign o_tag        = req_addr.f.tag;
  assign o_set_dirty  = store_hit;
  assign o_fill_tag   = ret_beat && i_ret_last;
  assign o_fill_way   = victim_ptr;
  assign o_victim_way = victim_ptr;

  // store data on hit, return beat during refill
  assign o_word_we   = store_hit || ret_beat;
  assign o_word_way  = in_refill ? victim_ptr : i_hit_way;
  assign o_word_sel  = in_refill ? beat_cnt : req_addr.f.offset[OFFSET_W-1 -: WORD_SEL_W];
  assign o_word_strb = in_refill ? {STRB_W{1'b1}} : req_wstrb;
  assign o_word_data = in_refill ? i_ret_data : req_wdata;

  // refilled line hits on the repeat lookup
  assert property (@(posedge i_clk) disable iff (i_rst) o_fill_tag |=> i_hit);

endmodule

/* logic/data_array.sv */
// Cache line store

`timescale 1ns/1ps

module data_array import cache_pkg::*; (
  input  logic                  i_clk,
  input  logic [INDEX_W-1:0]    i_index,
  input  logic                  i_hit_way,
  input  logic                  i_victim_way,
  input  logic [WORD_SEL_W-1:0] i_word_sel,
  input  logic                  i_word_we,
  input  logic                  i_word_way,
  input  logic [STRB_W-1:0]     i_word_strb,
  input  logic [DATA_W-1:0]     i_word_data,
  output logic [DATA_W-1:0]     o_rdata_word,
  output logic [LINE_W-1:0]     o_victim_line
);

  logic [LINE_W-1:0] line_q [NUM_WAYS][NUM_SETS];
  logic [LINE_W-1:0] hit_line;
  logic [LINE_W-1:0] wr_line;
  logic [DATA_W-1:0] old_word;
  logic [DATA_W-1:0] merged_word;

  // ------------------------------------------------------------
  // read side
  // ------------------------------------------------------------
  assign hit_line      = line_q[i_hit_way][i_index];
  assign o_rdata_word  = hit_line[i_word_sel*DATA_W +: DATA_W];
  assign o_victim_line = line_q[i_victim_way][i_index];  // whole line for write-back

  // ------------------------------------------------------------
  // byte merge and write
  // ------------------------------------------------------------
  assign wr_line  = line_q[i_word_way][i_index];
  assign old_word = wr_line[i_word_sel*DATA_W +: DATA_W];

  always_comb begin
    merged_word = old_word;
    for (int b = 0; b < STRB_W; b++) begin
      if (i_word_strb[b]) merged_word[b*8 +: 8] = i_word_data[b*8 +: 8];
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_word_we) begin
      line_q[i_word_way][i_index][i_word_sel*DATA_W +: DATA_W] <= merged_word;
    end
  end

  // set index must come from a registered request when writing
  assert property (@(posedge i_clk) i_word_we |-> !$isunknown(i_index));

endmodule

/* logic/tag_array.sv */
// Cache tag store

`timescale 1ns/1ps

module tag_array import cache_pkg::*; (
  input  logic               i_clk,
  input  logic               i_rst,
  input  logic [INDEX_W-1:0] i_index,
  input  logic [TAG_W-1:0]   i_tag,
  input  logic               i_set_dirty,
  input  logic               i_fill_tag,
  input  logic               i_fill_way,
  input  logic               i_victim_way,
  output logic               o_hit,
  output logic               o_hit_way,
  output logic               o_victim_dirty,
  output logic [TAG_W-1:0]   o_victim_tag
);

  logic [TAG_W-1:0]    tag_q   [NUM_WAYS][NUM_SETS];
  logic [NUM_SETS-1:0] valid_q [NUM_WAYS];
  logic [NUM_SETS-1:0] dirty_q [NUM_WAYS];
  logic [NUM_WAYS-1:0] way_hit;

  // ------------------------------------------------------------
  // compare
  // ------------------------------------------------------------
  always_comb begin
    for (int w = 0; w < NUM_WAYS; w++) begin
      way_hit[w] = valid_q[w][i_index] && (tag_q[w][i_index] == i_tag);
    end
  end

  assign o_hit          = |way_hit;
  assign o_hit_way      = way_hit[1];  // way 0 when no hit
  assign o_victim_dirty = valid_q[i_victim_way][i_index] && dirty_q[i_victim_way][i_index];
  assign o_victim_tag   = tag_q[i_victim_way][i_index];

  // ------------------------------------------------------------
  // update
  // ------------------------------------------------------------
  always_ff @(posedge i_clk) begin
    if (i_fill_tag) tag_q[i_fill_way][i_index] <= i_tag;
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      for (int w = 0; w < NUM_WAYS; w++) begin
        valid_q[w] <= '0;  // all lines invalid
        dirty_q[w] <= '0;
      end
    end else begin
      if (i_set_dirty) dirty_q[o_hit_way][i_index] <= 1'b1;
      if (i_fill_tag) begin
        valid_q[i_fill_way][i_index] <= 1'b1;
        dirty_q[i_fill_way][i_index] <= 1'b0;  // fresh line is clean
      end
    end
  end

  // refill only after a miss, so a tag lives in one way at most
  assert property (@(posedge i_clk) disable iff (i_rst) !(way_hit[0] && way_hit[1]));

endmodule

/* logic/cache_pkg.sv */
// Data cache shared definitions

package cache_pkg;

  // ------------------------------------------------------------
  // geometry
  // ------------------------------------------------------------
  localparam int ADDR_W         = 32;
  localparam int DATA_W         = 64;                        // cpu word
  localparam int STRB_W         = DATA_W / 8;
  localparam int WORDS_PER_LINE = 4;
  localparam int LINE_W         = WORDS_PER_LINE * DATA_W;   // 256 bits, 32 bytes
  localparam int WORD_SEL_W     = $clog2(WORDS_PER_LINE);
  localparam int NUM_WAYS       = 2;
  localparam int NUM_SETS       = 64;
  localparam int OFFSET_W       = 5;                         // byte in line
  localparam int INDEX_W        = $clog2(NUM_SETS);
  localparam int TAG_W          = ADDR_W - INDEX_W - OFFSET_W;

  // ------------------------------------------------------------
  // controller states
  // ------------------------------------------------------------
  localparam logic [2:0] ST_IDLE       = 3'd0;
  localparam logic [2:0] ST_LOOKUP     = 3'd1;
  localparam logic [2:0] ST_WRITEBACK  = 3'd2;
  localparam logic [2:0] ST_REFILL_REQ = 3'd3;
  localparam logic [2:0] ST_REFILL     = 3'd4;

  // address seen as one word or as its cache fields
  typedef struct packed {
    logic [TAG_W-1:0]    tag;
    logic [INDEX_W-1:0]  index;
    logic [OFFSET_W-1:0] offset;  // bits 4:3 pick the word
  } cache_addr_fields_t;

  typedef union packed {
    logic [ADDR_W-1:0]  raw;
    cache_addr_fields_t f;
  } cache_addr_t;

endpackage
